// ==== align_buffer.sv ====
// Alignment buffer
// Two-beat byte buffer written half by half, read through a rotating crossbar

`timescale 1ns/10ps

module align_buffer (
   input  logic                    clk_i,
   input  logic                    rst_ni,
   input  aligner_pkg::beat_t      push_dat_i,
   input  aligner_pkg::buf_ctrl_t  ctrl_i,
   input  aligner_pkg::offs_t      rot_offs_i,
   output aligner_pkg::beat_t      pop_dat_o
);

   // Byte index into the full buffer
   localparam int unsigned IDX_W = aligner_pkg::OFFS_W + 1;

   logic [aligner_pkg::BUF_BYTES-1:0][7:0]   buf_q;
   logic [aligner_pkg::BEAT_BYTES-1:0][IDX_W-1:0] sel;

   // ************************************************************************
   // Buffer halves
   // ************************************************************************

   // push_half picks lower or upper half, halves alternate beat by beat
   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         buf_q <= '0;
      end
      else if (ctrl_i.push_data)
      begin
         for (int b = 0; b < aligner_pkg::BEAT_BYTES; b++)
         begin
            buf_q[{ctrl_i.push_half, aligner_pkg::OFFS_W'(b)}] <= push_dat_i[8*b +: 8];
         end
      end
   end

   // ************************************************************************
   // Rotating crossbar
   // ************************************************************************

   // Odd pop half shifts the window by one beat, index wraps at 16
   for (genvar j = 0; j < aligner_pkg::BEAT_BYTES; j++)
   begin : g_lane
      assign sel[j] = IDX_W'(j)
                    + {1'b0, rot_offs_i}
                    + {ctrl_i.pop_half, {aligner_pkg::OFFS_W{1'b0}}};

      assign pop_dat_o[8*j +: 8] = buf_q[sel[j]];
   end

endmodule

// ==== align_fsm.sv ====
// Aligner control FSM
// Sequences push and pop beats, tracks buffer halves and holds the stall strobe

`timescale 1ns/10ps

module align_fsm #(
   parameter int unsigned LEN_W = 15
) (
   input  logic                      clk_i,
   input  logic                      rst_ni,
   input  logic                      trans_req_i,
   input  aligner_pkg::plan_flags_t  flags_i,
   input  aligner_pkg::strb_set_t    strb_i,
   input  logic [LEN_W-1:0]          push_beats_nb_i,
   input  logic [LEN_W-1:0]          pop_beats_nb_i,
   input  logic                      data_push_req_i,
   input  logic                      data_pop_req_i,
   output logic                      trans_gnt_o,
   output logic                      take_o,
   output aligner_pkg::buf_ctrl_t    ctrl_o,
   output logic                      data_push_gnt_o,
   output logic                      data_pop_gnt_o,
   output aligner_pkg::strb_t        data_pop_strb_o
);

   typedef enum logic [3:0] {
      S_IDLE,
      S_FIRST,
      S_SECOND,
      S_THIRD,
      S_RUN,
      S_PUSH_STALL,
      S_POP_STALL,
      S_SSLAST,
      S_SLAST,
      S_LAST
   } state_e;

   state_e                state_q, state_d;
   logic [LEN_W-1:0]      push_cnt_q;
   logic                  push_half_q;
   logic                  pop_half_q;
   aligner_pkg::strb_t    stall_strb_q;
   logic                  push_data;
   logic                  pop_data;
   logic                  store_strb;
   logic [2:0]            flag_sel;
   logic                  last_push;

   // Tail state once the final push beat is taken together with a pop
   function automatic state_e tail_state(input logic [2:0] sel);
      state_e st;
      case (sel)
         3'b001, 3'b100, 3'b101, 3'b111: st = S_LAST;
         default: st = S_SLAST;
      endcase
      return st;
   endfunction

   assign flag_sel  = {flags_i.pop_greater, flags_i.push_aligned, flags_i.pop_aligned};
   // Counter equals the count of beats before this one
   assign last_push = (push_cnt_q == push_beats_nb_i);

   // ************************************************************************
   // Next state and grants
   // ************************************************************************

   always_comb
   begin
      trans_gnt_o     = 1'b0;
      take_o          = 1'b0;
      data_push_gnt_o = 1'b0;
      data_pop_gnt_o  = 1'b0;
      data_pop_strb_o = '0;
      push_data       = 1'b0;
      pop_data        = 1'b0;
      store_strb      = 1'b0;
      state_d         = state_q;

      case (state_q)
         S_IDLE:
         begin
            trans_gnt_o = 1'b1;
            if (trans_req_i)
            begin
               take_o  = 1'b1;
               state_d = S_FIRST;
            end
         end

         // Fill the buffer before the first pop
         S_FIRST:
         begin
            data_push_gnt_o = 1'b1;
            if (data_push_req_i)
            begin
               push_data = 1'b1;
               if (push_beats_nb_i == '0)
               begin
                  if (!flags_i.pop_aligned && (flags_i.pop_greater || flags_i.push_aligned))
                  begin
                     state_d = S_SLAST;
                  end
                  else
                  begin
                     state_d = S_LAST;
                  end
               end
               else
               begin
                  case (flag_sel)
                     3'b010, 3'b100, 3'b110, 3'b111: state_d = S_THIRD;
                     default: state_d = S_SECOND;
                  endcase
               end
            end
         end

         S_SECOND:
         begin
            data_push_gnt_o = 1'b1;
            if (data_push_req_i)
            begin
               push_data = 1'b1;
               if (push_beats_nb_i == LEN_W'(1))
               begin
                  case (flag_sel)
                     3'b000, 3'b011: state_d = S_SLAST;
                     3'b001, 3'b101: state_d = S_LAST;
                     default: state_d = S_SSLAST;
                  endcase
               end
               else
               begin
                  state_d = S_THIRD;
               end
            end
         end

         // Streaming, a push is granted only alongside a pop
         S_THIRD, S_RUN, S_POP_STALL:
         begin
            data_pop_gnt_o  = 1'b1;
            data_push_gnt_o = data_pop_req_i;
            store_strb      = 1'b1;
            if (state_q == S_THIRD)
            begin
               data_pop_strb_o = strb_i.first;
            end
            else if (state_q == S_RUN)
            begin
               data_pop_strb_o = '1;
            end
            else
            begin
               data_pop_strb_o = stall_strb_q;
            end

            if (!data_pop_req_i)
            begin
               state_d = S_POP_STALL;
            end
            else
            begin
               pop_data = 1'b1;
               if (data_push_req_i)
               begin
                  push_data = 1'b1;
                  state_d   = last_push ? tail_state(flag_sel) : S_RUN;
               end
               else
               begin
                  state_d = S_PUSH_STALL;
               end
            end
         end

         S_PUSH_STALL:
         begin
            data_push_gnt_o = 1'b1;
            data_pop_strb_o = stall_strb_q;
            if (data_push_req_i)
            begin
               push_data = 1'b1;
               state_d   = last_push ? tail_state(flag_sel) : S_RUN;
            end
         end

         // Drain states, the buffer already holds every push beat
         S_SSLAST:
         begin
            data_pop_gnt_o  = 1'b1;
            data_pop_strb_o = '1;
            if (data_pop_req_i)
            begin
               pop_data = 1'b1;
               state_d  = S_SLAST;
            end
         end

         S_SLAST:
         begin
            data_pop_gnt_o  = 1'b1;
            data_pop_strb_o = (pop_beats_nb_i == LEN_W'(1)) ? strb_i.first : '1;
            if (data_pop_req_i)
            begin
               pop_data = 1'b1;
               state_d  = S_LAST;
            end
         end

         S_LAST:
         begin
            data_pop_gnt_o  = 1'b1;
            data_pop_strb_o = (pop_beats_nb_i == '0) ? strb_i.single : strb_i.last;
            if (data_pop_req_i)
            begin
               pop_data = 1'b1;
               state_d  = S_IDLE;
            end
         end

         default:
         begin
            state_d = S_IDLE;
         end
      endcase
   end

   // ************************************************************************
   // State, counter and half toggles
   // ************************************************************************

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         state_q      <= S_IDLE;
         push_cnt_q   <= '0;
         push_half_q  <= 1'b0;
         pop_half_q   <= 1'b0;
         stall_strb_q <= '0;
      end
      else
      begin
         state_q <= state_d;
         if (take_o)
         begin
            push_cnt_q  <= '0;
            push_half_q <= 1'b0;
            pop_half_q  <= 1'b0;
         end
         else
         begin
            if (push_data)
            begin
               push_cnt_q  <= push_cnt_q + LEN_W'(1);
               push_half_q <= ~push_half_q;
            end
            if (pop_data)
            begin
               pop_half_q <= ~pop_half_q;
            end
         end
         if (store_strb)
         begin
            stall_strb_q <= data_pop_strb_o;
         end
      end
   end

   // Pop offset above push offset reads one beat further back
   always_comb
   begin
      ctrl_o.push_data = push_data;
      ctrl_o.push_half = push_half_q;
      ctrl_o.pop_half  = pop_half_q ^ flags_i.pop_greater;
   end

endmodule

// ==== aligner_pkg.sv ====
// Aligner package
// Beat geometry and the packed structs shared by the byte-alignment engine

package aligner_pkg;

   // ************************************************************************
   // Beat geometry
   // ************************************************************************

   // Bytes per data beat
   localparam int unsigned BEAT_BYTES = 8;
   // Width of a byte offset within one beat
   localparam int unsigned OFFS_W = 3;
   // Alignment buffer holds two beats
   localparam int unsigned BUF_BYTES = 2 * BEAT_BYTES;

   typedef logic [8*BEAT_BYTES-1:0] beat_t;
   typedef logic [BEAT_BYTES-1:0] strb_t;
   typedef logic [OFFS_W-1:0] offs_t;

   // ************************************************************************
   // Shared structs
   // ************************************************************************

   // Length-independent part of a transfer descriptor
   typedef struct packed {
      offs_t pop_offs;
      offs_t push_offs;
   } trans_offs_t;

   // Alignment flags that steer the control sequence
   typedef struct packed {
      logic pop_greater;
      logic push_aligned;
      logic pop_aligned;
   } plan_flags_t;

   // Strobes of the first, last and single-beat pop
   typedef struct packed {
      strb_t first;
      strb_t last;
      strb_t single;
   } strb_set_t;

   // Buffer write and crossbar control
   typedef struct packed {
      logic push_data;
      logic push_half;
      logic pop_half;
   } buf_ctrl_t;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the aligner testbench with Verilator, pass only if the log shows success
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_trans_aligner \
   -f trans_aligner.f -o tb_sim \
   && ./obj_dir/tb_sim > sim.log 2>&1 \
   || echo "Build or simulation run did not complete"
cat sim.log 2>/dev/null
grep -q "^Everything OK$" sim.log && echo "PASS" && exit 0 || echo "FAIL" && exit 1

// ==== tb_clock_gen.sv ====
// Testbench clock and reset source
// Free-running clock and an active-low reset held for a few cycles

`timescale 1ns/10ps

module tb_clock_gen #(
   parameter int unsigned PERIOD_NS    = 4,
   parameter int unsigned RESET_CYCLES = 3
) (
   output logic clk_o,
   output logic rst_no
);

   initial
   begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

   // Release on a rising edge so the DUT leaves reset cleanly
   initial
   begin
      rst_no <= 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      rst_no <= 1'b1;
   end

endmodule

// ==== tb_trans_aligner.sv ====
// Testbench for the byte-alignment engine
// Random transfers under push and pop back-pressure, checked against a byte-stream model

`timescale 1ns/10ps

module tb_trans_aligner;

   localparam int unsigned LEN_W      = 15;
   localparam int          BEAT_BYTES = int'(aligner_pkg::BEAT_BYTES);
   localparam int          NUM_TRANS  = 300;
   localparam int          MAX_WAIT   = 1000;

   logic                     clk_i;
   logic                     rst_ni;
   logic                     trans_req_i;
   aligner_pkg::trans_offs_t trans_offs_i;
   logic [LEN_W-1:0]         trans_len_i;
   logic                     trans_gnt_o;
   aligner_pkg::beat_t       data_push_dat_i;
   logic                     data_push_req_i;
   logic                     data_push_gnt_o;
   aligner_pkg::beat_t       data_pop_dat_o;
   aligner_pkg::strb_t       data_pop_strb_o;
   logic                     data_pop_req_i;
   logic                     data_pop_gnt_o;

   int unsigned data_errs;
   int unsigned strb_errs;
   int unsigned proto_errs;
   logic        timed_out;
   // Bytes of the current transfer, in stream order
   logic [7:0]  stream_q[$];

   tb_clock_gen #(
      .PERIOD_NS    (4),
      .RESET_CYCLES (3)
   ) i_clock_gen (
      .clk_o  (clk_i),
      .rst_no (rst_ni)
   );

   trans_aligner #(
      .LEN_W (LEN_W)
   ) DUT (
      .clk_i           (clk_i),
      .rst_ni          (rst_ni),
      .trans_req_i     (trans_req_i),
      .trans_offs_i    (trans_offs_i),
      .trans_len_i     (trans_len_i),
      .trans_gnt_o     (trans_gnt_o),
      .data_push_dat_i (data_push_dat_i),
      .data_push_req_i (data_push_req_i),
      .data_push_gnt_o (data_push_gnt_o),
      .data_pop_dat_o  (data_pop_dat_o),
      .data_pop_strb_o (data_pop_strb_o),
      .data_pop_req_i  (data_pop_req_i),
      .data_pop_gnt_o  (data_pop_gnt_o)
   );

   // ************************************************************************
   // Byte-stream model
   // ************************************************************************

   // Push beat k with random filler in the lanes outside the transfer
   function automatic aligner_pkg::beat_t push_beat(input int k, input int offs, input int len);
      aligner_pkg::beat_t beat;
      int                 idx;
      for (int b = 0; b < BEAT_BYTES; b++)
      begin
         idx = k * BEAT_BYTES + b - offs;
         if (idx >= 0 && idx <= len)
            beat[8*b +: 8] = stream_q[idx];
         else
            beat[8*b +: 8] = 8'($urandom);
      end
      return beat;
   endfunction

   // Expected strobe and bytes of pop beat n follow from the pop offset
   task automatic check_pop_beat(input int n, input int offs, input int len);
      aligner_pkg::strb_t exp_strb;
      int                 idx;
      for (int lane = 0; lane < BEAT_BYTES; lane++)
      begin
         idx = n * BEAT_BYTES + lane - offs;
         exp_strb[lane] = (idx >= 0) && (idx <= len);
      end
      assert (data_pop_strb_o == exp_strb)
      else
      begin
         strb_errs++;
         $display("Error at %0t ns: pop beat %0d strobe %b, expected %b",
                  $time, n, data_pop_strb_o, exp_strb);
      end
      for (int lane = 0; lane < BEAT_BYTES; lane++)
      begin
         idx = n * BEAT_BYTES + lane - offs;
         if (exp_strb[lane])
         begin
            assert (data_pop_dat_o[8*lane +: 8] == stream_q[idx])
            else
            begin
               data_errs++;
               $display("Error at %0t ns: pop beat %0d lane %0d byte %h, expected %h",
                        $time, n, lane, data_pop_dat_o[8*lane +: 8], stream_q[idx]);
            end
         end
      end
   endtask

   // ************************************************************************
   // Stimulus
   // ************************************************************************

   task automatic run_transfer();
      int pop_offs;
      int push_offs;
      int len;
      int push_exp;
      int pop_exp;
      int push_cnt;
      int pop_cnt;
      int waited;
      int push_bias;
      int pop_bias;
      pop_offs  = int'($urandom_range(0, 7));
      push_offs = int'($urandom_range(0, 7));
      len       = int'($urandom_range(0, 63));
      push_bias = int'($urandom_range(1, 4));
      pop_bias  = int'($urandom_range(1, 4));
      stream_q.delete();
      for (int i = 0; i <= len; i++)
         stream_q.push_back(8'($urandom));
      push_exp = (push_offs + len + BEAT_BYTES) / BEAT_BYTES;
      pop_exp  = (pop_offs + len + BEAT_BYTES) / BEAT_BYTES;

      @(posedge clk_i);
      trans_req_i  <= 1'b1;
      trans_offs_i <= {aligner_pkg::offs_t'(pop_offs), aligner_pkg::offs_t'(push_offs)};
      trans_len_i  <= LEN_W'(len);
      waited = 0;
      @(negedge clk_i);
      while (!trans_gnt_o && !timed_out)
      begin
         waited++;
         if (waited > MAX_WAIT)
         begin
            $display("Timeout: the descriptor grant never came back high");
            timed_out = 1'b1;
         end
         @(negedge clk_i);
      end

      // First rising edge here takes the descriptor
      push_cnt = 0;
      pop_cnt  = 0;
      waited   = 0;
      while (pop_cnt < pop_exp && !timed_out)
      begin
         @(posedge clk_i);
         // A stray descriptor request must be ignored mid-transfer
         trans_req_i     <= 1'($urandom_range(0, 1));
         trans_offs_i    <= {aligner_pkg::offs_t'($urandom), aligner_pkg::offs_t'($urandom)};
         trans_len_i     <= LEN_W'($urandom);
         data_push_req_i <= ($urandom_range(0, 3) < push_bias);
         data_push_dat_i <= push_beat(push_cnt, push_offs, len);
         data_pop_req_i  <= ($urandom_range(0, 3) < pop_bias);
         @(negedge clk_i);
         assert (!trans_gnt_o)
         else
         begin
            proto_errs++;
            $display("Error at %0t ns: descriptor grant high during a transfer", $time);
         end
         waited++;
         if (data_push_req_i && data_push_gnt_o)
         begin
            assert (push_cnt < push_exp)
            else
            begin
               proto_errs++;
               $display("Error at %0t ns: push beat %0d taken, only %0d expected",
                        $time, push_cnt + 1, push_exp);
            end
            push_cnt++;
            waited = 0;
         end
         if (data_pop_req_i && data_pop_gnt_o)
         begin
            check_pop_beat(pop_cnt, pop_offs, len);
            pop_cnt++;
            waited = 0;
         end
         if (waited > MAX_WAIT)
         begin
            $display("Timeout: transfer stalled after %0d of %0d pop beats", pop_cnt, pop_exp);
            timed_out = 1'b1;
         end
      end

      if (!timed_out)
      begin
         @(posedge clk_i);
         trans_req_i     <= 1'b0;
         data_push_req_i <= 1'b0;
         data_pop_req_i  <= 1'b0;
         @(negedge clk_i);
         assert (push_cnt == push_exp)
         else
         begin
            proto_errs++;
            $display("Error at %0t ns: %0d push beats taken, expected %0d",
                     $time, push_cnt, push_exp);
         end
         assert (trans_gnt_o)
         else
         begin
            proto_errs++;
            $display("Error at %0t ns: descriptor grant low after the final pop", $time);
         end
      end
   endtask

   initial
   begin
      void'($urandom(69));
      trans_req_i     <= 1'b0;
      trans_offs_i    <= '0;
      trans_len_i     <= '0;
      data_push_dat_i <= '0;
      data_push_req_i <= 1'b0;
      data_pop_req_i  <= 1'b0;
      data_errs       = 0;
      strb_errs       = 0;
      proto_errs      = 0;
      timed_out       = 1'b0;

      @(negedge clk_i);
      while (!rst_ni && !timed_out)
      begin
         if ($time > 100)
         begin
            $display("Timeout: reset was never released");
            timed_out = 1'b1;
         end
         @(negedge clk_i);
      end

      // Idle outputs right after reset
      assert (trans_gnt_o && !data_push_gnt_o && !data_pop_gnt_o && data_pop_strb_o == '0)
      else
      begin
         proto_errs++;
         $display("Error at %0t ns: outputs after reset are not idle", $time);
      end

      for (int t = 0; t < NUM_TRANS && !timed_out; t++)
         run_transfer();

      $display("Error counts: data %0d, strobe %0d, protocol %0d, timeout %0d",
               data_errs, strb_errs, proto_errs, timed_out);
      if (!timed_out && data_errs == 0 && strb_errs == 0 && proto_errs == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

// ==== trans_aligner.f ====
aligner_pkg.sv
trans_planner.sv
align_buffer.sv
align_fsm.sv
trans_aligner.sv
trans_aligner_asserts.sv
tb_clock_gen.sv
tb_trans_aligner.sv

// ==== trans_aligner.sv ====
// Byte-alignment engine top level
// Moves a byte stream from push beat offsets to pop beat offsets with strobes

`timescale 1ns/10ps

module trans_aligner #(
   parameter int unsigned LEN_W = 15
) (
   input  logic                      clk_i,
   input  logic                      rst_ni,

   input  logic                      trans_req_i,
   input  aligner_pkg::trans_offs_t  trans_offs_i,
   input  logic [LEN_W-1:0]          trans_len_i,
   output logic                      trans_gnt_o,

   input  aligner_pkg::beat_t        data_push_dat_i,
   input  logic                      data_push_req_i,
   output logic                      data_push_gnt_o,

   output aligner_pkg::beat_t        data_pop_dat_o,
   output aligner_pkg::strb_t        data_pop_strb_o,
   input  logic                      data_pop_req_i,
   output logic                      data_pop_gnt_o
);

   logic                       take;
   aligner_pkg::plan_flags_t   flags;
   aligner_pkg::strb_set_t     strb_set;
   logic [LEN_W-1:0]           push_beats_nb;
   logic [LEN_W-1:0]           pop_beats_nb;
   aligner_pkg::offs_t         rot_offs;
   aligner_pkg::buf_ctrl_t     buf_ctrl;

   trans_planner #(
      .LEN_W (LEN_W)
   ) i_planner (
      .clk_i           (clk_i),
      .rst_ni          (rst_ni),
      .take_i          (take),
      .trans_offs_i    (trans_offs_i),
      .trans_len_i     (trans_len_i),
      .flags_o         (flags),
      .strb_o          (strb_set),
      .push_beats_nb_o (push_beats_nb),
      .pop_beats_nb_o  (pop_beats_nb),
      .rot_offs_o      (rot_offs)
   );

   align_buffer i_buffer (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .push_dat_i (data_push_dat_i),
      .ctrl_i     (buf_ctrl),
      .rot_offs_i (rot_offs),
      .pop_dat_o  (data_pop_dat_o)
   );

   align_fsm #(
      .LEN_W (LEN_W)
   ) i_fsm (
      .clk_i           (clk_i),
      .rst_ni          (rst_ni),
      .trans_req_i     (trans_req_i),
      .flags_i         (flags),
      .strb_i          (strb_set),
      .push_beats_nb_i (push_beats_nb),
      .pop_beats_nb_i  (pop_beats_nb),
      .data_push_req_i (data_push_req_i),
      .data_pop_req_i  (data_pop_req_i),
      .trans_gnt_o     (trans_gnt_o),
      .take_o          (take),
      .ctrl_o          (buf_ctrl),
      .data_push_gnt_o (data_push_gnt_o),
      .data_pop_gnt_o  (data_pop_gnt_o),
      .data_pop_strb_o (data_pop_strb_o)
   );

endmodule

// ==== trans_aligner_asserts.sv ====
// Protocol assertions for the byte-alignment engine
// Bound to the top level, checks grant exclusivity and pop strobes

`timescale 1ns/10ps

module trans_aligner_asserts (
   input logic               clk_i,
   input logic               rst_ni,
   input logic               trans_gnt_o,
   input logic               data_push_gnt_o,
   input logic               data_pop_gnt_o,
   input logic               data_pop_req_i,
   input aligner_pkg::strb_t data_pop_strb_o
);

   // Data grants only exist inside a transfer
   no_data_gnt_in_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
      trans_gnt_o |-> (!data_push_gnt_o && !data_pop_gnt_o))
      else $error("Data grant while the descriptor grant is high");

   // Every accepted pop beat carries at least one byte
   pop_strb_nonzero: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (data_pop_req_i && data_pop_gnt_o) |-> (data_pop_strb_o != '0))
      else $error("Pop beat accepted with an empty strobe");

   grants_after_reset: assert property (@(posedge clk_i)
      $rose(rst_ni) |-> (trans_gnt_o && !data_push_gnt_o && !data_pop_gnt_o))
      else $error("Grants not idle in the cycle after reset");

endmodule

bind trans_aligner trans_aligner_asserts i_asserts (
   .clk_i           (clk_i),
   .rst_ni          (rst_ni),
   .trans_gnt_o     (trans_gnt_o),
   .data_push_gnt_o (data_push_gnt_o),
   .data_pop_gnt_o  (data_pop_gnt_o),
   .data_pop_req_i  (data_pop_req_i),
   .data_pop_strb_o (data_pop_strb_o)
);

// ==== trans_planner.sv ====
// Transfer planner
// Holds the descriptor and derives beat counts, alignment flags,
// crossbar rotation and pop strobes

`timescale 1ns/10ps

module trans_planner #(
   parameter int unsigned LEN_W = 15
) (
   input  logic                      clk_i,
   input  logic                      rst_ni,
   input  logic                      take_i,
   input  aligner_pkg::trans_offs_t  trans_offs_i,
   input  logic [LEN_W-1:0]          trans_len_i,
   output aligner_pkg::plan_flags_t  flags_o,
   output aligner_pkg::strb_set_t    strb_o,
   output logic [LEN_W-1:0]          push_beats_nb_o,
   output logic [LEN_W-1:0]          pop_beats_nb_o,
   output aligner_pkg::offs_t        rot_offs_o
);

   localparam aligner_pkg::strb_t ALL_ONES = {aligner_pkg::BEAT_BYTES{1'b1}};

   aligner_pkg::trans_offs_t       offs_q;
   logic [LEN_W-1:0]               len_q;
   logic [LEN_W-1:0]               beats_nb;
   aligner_pkg::offs_t             len_rem;
   logic [aligner_pkg::OFFS_W:0]   push_end;
   logic [aligner_pkg::OFFS_W:0]   pop_end;
   aligner_pkg::offs_t             last_shift;
   aligner_pkg::offs_t             single_shift;
   aligner_pkg::strb_t             single_mask;

   // Descriptor registers, loaded when the FSM takes a request
   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         offs_q <= '0;
         len_q  <= '0;
      end
      else if (take_i)
      begin
         offs_q <= trans_offs_i;
         len_q  <= trans_len_i;
      end
   end

   // ************************************************************************
   // Beat counts and flags
   // ************************************************************************

   // Whole beats and the byte remainder of length
   assign beats_nb = len_q >> aligner_pkg::OFFS_W;
   assign len_rem  = len_q[aligner_pkg::OFFS_W-1:0];

   // Top bit set when offset plus remainder crosses into another beat
   assign push_end = {1'b0, offs_q.push_offs} + {1'b0, len_rem};
   assign pop_end  = {1'b0, offs_q.pop_offs} + {1'b0, len_rem};

   assign push_beats_nb_o = beats_nb + LEN_W'(push_end[aligner_pkg::OFFS_W]);
   assign pop_beats_nb_o  = beats_nb + LEN_W'(pop_end[aligner_pkg::OFFS_W]);

   always_comb
   begin
      flags_o.pop_greater  = offs_q.pop_offs > offs_q.push_offs;
      flags_o.push_aligned = ~push_end[aligner_pkg::OFFS_W];
      flags_o.pop_aligned  = ~pop_end[aligner_pkg::OFFS_W];
   end

   // Wraps modulo one beat, the FSM adds the half when pop offset is greater
   assign rot_offs_o = offs_q.push_offs - offs_q.pop_offs;

   // ************************************************************************
   // Pop strobes
   // ************************************************************************

   // Shift amounts wrap within one beat
   assign last_shift   = 3'd7 - len_rem - offs_q.pop_offs;
   assign single_shift = 3'd7 - len_rem;
   assign single_mask  = ALL_ONES >> single_shift;

   always_comb
   begin
      strb_o.first  = ALL_ONES << offs_q.pop_offs;
      strb_o.last   = ALL_ONES >> last_shift;
      strb_o.single = single_mask << offs_q.pop_offs;
   end

endmodule
